// File: source/hub_settings.svh
// --------------------------------------
// hub controller settings
// RAM geometry, chip register widths
// sequencer timeout, acknowledge codes
// --------------------------------------

`ifndef HUB_SETTINGS_SVH
`define HUB_SETTINGS_SVH

// hub RAM, 2048 x 32
`define HUB_ADDR_W      11
`define HUB_DATA_W      32
`define HUB_MEM_DEPTH   2048

// ethernet chip register bus
`define REG_OFFSET_W    8           // register offset
`define REG_DATA_W      16          // register data, word access

// ack/resp wait timeout, 4096 cycles at 49.152 MHz is about 83 us
`define HUB_TIMEOUT_W   12
`define HUB_TIMEOUT_MAX 4095        // last count before giving up

// firewire acknowledge codes
`define ACK_CODE_W      4
`define ACK_DONE        4'h1        // write done, nothing follows
`define ACK_PEND        4'h2        // read pending, response follows

`define NODE_W          4           // node count minus one, 1..16 nodes

`endif

// File: source/hubPkg.sv
// --------------------------------------
// hub controller types
// status codes and status word views
// completion strobes, register request
// --------------------------------------

`include "hub_settings.svh"

package hubPkg;

	// status codes
	// bit 5 nodes known, bits 4:3 ethernet line, bits 2:0 firewire line
	typedef enum logic [5:0] {
		StInit       = 6'b000000,  // chip init running
		StSetupIdle  = 6'b010000,  // wait for pc request or node-set
		StSetupTx    = 6'b000001,
		StSetupAck   = 6'b000100,
		StSetupResp  = 6'b000110,
		StSetupReply = 6'b011000,
		StPcIdle     = 6'b110000,  // pc command mode
		StPcTx       = 6'b100001,
		StPcAck      = 6'b100100,
		StPcResp     = 6'b100110,
		StPcReply    = 6'b111000,
		StBcReq      = 6'b100011,  // broadcast mode
		StBcAck      = 6'b100101,
		StBcCollect  = 6'b100111,
		StBcReply    = 6'b101000
	} hubStatus_e;

	// same status word, whole code or per-line fields
	typedef union packed {
		hubStatus_e code;          // sequencer view
		struct packed {
			logic       nodesKnown;
			logic [1:0] ethLine;   // 01 bc resp out, 10 pc req in, 11 pc resp out
			logic [2:0] fwLine;    // firewire tx/rx phase
		} lines;                   // arbiter view
	} hubStatus_u;

	// one-cycle completion strobes from the links
	typedef struct packed {
		logic ethInitDone;
		logic nodeSet;         // node count received from pc
		logic pcReqNew;
		logic pcReqTxed;
		logic bcReqTxed;
		logic ackRxed;
		logic respRxed;
		logic bcRespRxed;      // one per node
		logic transDone;       // reply sent to pc
	} hubEvents_t;

	// register bus request plus ethernet port of hub RAM
	typedef struct packed {
		logic [`REG_OFFSET_W-1:0] offset;
		logic                     isWord;     // 0 byte, 1 word
		logic                     write;
		logic [`REG_DATA_W-1:0]   writeData;
		logic                     newCommand; // start a register access
		logic [`HUB_ADDR_W-1:0]   memAddr;
		logic                     memWen;
		logic [`HUB_DATA_W-1:0]   memWdata;
	} regReq_t;

endpackage

// File: source/hubSequencer.sv
// --------------------------------------
// hub status sequencer
// setup, pc command and broadcast flows
// ack/resp timeout, bc response counter
// --------------------------------------

`timescale 1ns/100ps

`include "hub_settings.svh"

module hubSequencer (
	input  logic                   sysclk,
	input  logic                   RSTN,
	input  hubPkg::hubEvents_t     events,
	input  logic [`ACK_CODE_W-1:0] ackCode,
	input  logic [`NODE_W-1:0]     numNode,
	input  logic                   modeBroadcast,
	output hubPkg::hubStatus_u     status,
	output logic                   bcModeLed
);

	hubPkg::hubStatus_u           statusQ;
	hubPkg::hubStatus_e           stateNext;
	logic [`HUB_TIMEOUT_W-1:0]    timeoutCnt;
	logic [`NODE_W-1:0]           pktCount;    // bc responses so far
	logic [`NODE_W-1:0]           numNodeQ;
	logic                         modeBc;
	logic                         timeoutHit;
	logic                         inWait;

	// states that give up after the timeout
	function automatic logic isTimedWait(input hubPkg::hubStatus_e s);
		return s inside {hubPkg::StSetupAck, hubPkg::StSetupResp,
			hubPkg::StPcAck, hubPkg::StPcResp};
	endfunction

	assign inWait     = isTimedWait(statusQ.code);
	assign timeoutHit = (timeoutCnt == `HUB_TIMEOUT_W'(`HUB_TIMEOUT_MAX));

	// --------------------------------------
	// next state
	// --------------------------------------
	always_comb begin
		stateNext = statusQ.code;  // hold by default, stray strobes ignored
		case (statusQ.code)
			hubPkg::StInit:
				if (events.ethInitDone) stateNext = hubPkg::StSetupIdle;
			hubPkg::StSetupIdle: begin
				if (events.nodeSet) begin  // node-set beats a new request
					if (modeBroadcast)
						stateNext = hubPkg::StBcReq;
					else
						stateNext = hubPkg::StPcIdle;
				end else if (events.pcReqNew) begin
					stateNext = hubPkg::StSetupTx;
				end
			end
			hubPkg::StSetupTx:
				if (events.pcReqTxed) stateNext = hubPkg::StSetupAck;
			hubPkg::StSetupAck: begin
				// pend waits for data, done and error codes both end here
				if (events.ackRxed) begin
					if (ackCode == `ACK_PEND)
						stateNext = hubPkg::StSetupResp;
					else
						stateNext = hubPkg::StSetupIdle;
				end else if (timeoutHit) begin
					stateNext = hubPkg::StSetupIdle;
				end
			end
			hubPkg::StSetupResp: begin
				if (events.respRxed)
					stateNext = hubPkg::StSetupReply;
				else if (timeoutHit)
					stateNext = hubPkg::StSetupIdle;
			end
			hubPkg::StSetupReply:
				if (events.transDone) stateNext = hubPkg::StSetupIdle;
			// pc command mode, same handshake
			hubPkg::StPcIdle:
				if (events.pcReqNew) stateNext = hubPkg::StPcTx;
			hubPkg::StPcTx:
				if (events.pcReqTxed) stateNext = hubPkg::StPcAck;
			hubPkg::StPcAck: begin
				if (events.ackRxed) begin
					if (ackCode == `ACK_PEND)
						stateNext = hubPkg::StPcResp;
					else
						stateNext = hubPkg::StPcIdle;
				end else if (timeoutHit) begin
					stateNext = hubPkg::StPcIdle;
				end
			end
			hubPkg::StPcResp: begin
				if (events.respRxed)
					stateNext = hubPkg::StPcReply;
				else if (timeoutHit)
					stateNext = hubPkg::StPcIdle;
			end
			hubPkg::StPcReply:
				if (events.transDone) stateNext = hubPkg::StPcIdle;
			// broadcast mode
			hubPkg::StBcReq:
				if (events.bcReqTxed) stateNext = hubPkg::StBcAck;
			hubPkg::StBcAck: begin
				if (events.ackRxed) begin
					if (ackCode == `ACK_DONE)
						stateNext = hubPkg::StBcCollect;
					else
						stateNext = hubPkg::StBcReq;  // bad ack, send again
				end
			end
			hubPkg::StBcCollect:
				if (events.bcRespRxed && pktCount == numNodeQ)  // last node
					stateNext = hubPkg::StBcReply;
			hubPkg::StBcReply:
				if (events.transDone) stateNext = hubPkg::StBcReq;
			default:
				stateNext = hubPkg::StInit;
		endcase
	end

	// --------------------------------------
	// registers
	// --------------------------------------
	always_ff @(posedge sysclk or negedge RSTN) begin
		if (!RSTN) begin
			statusQ.code <= hubPkg::StInit;
			timeoutCnt   <= '0;
			pktCount     <= '0;
			numNodeQ     <= '0;
			modeBc       <= 1'b0;
		end else begin
			statusQ.code <= stateNext;
			// counts only while staying in a wait state
			if (inWait && stateNext == statusQ.code)
				timeoutCnt <= timeoutCnt + 1'b1;
			else
				timeoutCnt <= '0;
			if (stateNext != hubPkg::StBcCollect)
				pktCount <= '0;
			else if (statusQ.code == hubPkg::StBcCollect && events.bcRespRxed)
				pktCount <= pktCount + 1'b1;
			// mode fixed once nodes are known
			if (statusQ.code == hubPkg::StSetupIdle && events.nodeSet) begin
				modeBc   <= modeBroadcast;
				numNodeQ <= numNode;
			end
		end
	end

	assign status    = statusQ;
	assign bcModeLed = modeBc;  // lit in broadcast mode

	// --------------------------------------
	// checks
	// --------------------------------------
	statusLegal: assert property (@(posedge sysclk) disable iff (!RSTN)
		statusQ.code inside {hubPkg::StInit, hubPkg::StSetupIdle, hubPkg::StSetupTx,
			hubPkg::StSetupAck, hubPkg::StSetupResp, hubPkg::StSetupReply,
			hubPkg::StPcIdle, hubPkg::StPcTx, hubPkg::StPcAck, hubPkg::StPcResp,
			hubPkg::StPcReply, hubPkg::StBcReq, hubPkg::StBcAck,
			hubPkg::StBcCollect, hubPkg::StBcReply})
		else $error("status left the code set: %b", statusQ);

	timeoutIdle: assert property (@(posedge sysclk) disable iff (!RSTN)
		!inWait |-> timeoutCnt == '0)
		else $error("timeout count %0d outside wait state", timeoutCnt);

endmodule

// File: source/regBusArbiter.sv
// --------------------------------------
// ethernet register bus arbiter
// init, transmit or receive owns the
// chip registers and RAM port B
// --------------------------------------

`timescale 1ns/100ps

module regBusArbiter (
	input  hubPkg::hubStatus_u status,
	input  hubPkg::regReq_t    initReq,
	input  hubPkg::regReq_t    transReq,
	input  hubPkg::regReq_t    recvReq,
	output hubPkg::regReq_t    regBus
);

	logic initOwn;
	logic transOwn;
	logic recvOwn;

	// --------------------------------------
	// owner from status, in priority order
	// --------------------------------------
	assign initOwn  = (status.code == hubPkg::StInit);
	assign transOwn = !initOwn && status.lines.ethLine[0];  // reply going to pc
	assign recvOwn  = !initOwn && !status.lines.ethLine[0]
		&& status.lines.ethLine[1];                         // pc request coming in

	// only the owner's request gets through
	always_comb begin
		if (initOwn) begin
			regBus = initReq;
		end else if (transOwn) begin
			regBus = transReq;
		end else if (recvOwn) begin
			regBus = recvReq;
		end else begin
			regBus        = '0;    // no command, no RAM write
			regBus.isWord = 1'b1;  // bus parks in word mode
		end
	end

	// --------------------------------------
	// checks
	// --------------------------------------
	// init never touches the RAM and transmit only reads it
	memWenOwner: assert final (!regBus.memWen || recvOwn)
		else $error("RAM write on port B without receive owning the bus");

endmodule

// File: source/hubMemory.sv
// --------------------------------------
// hub RAM, 2048 x 32, true dual port
// port A firewire link, port B ethernet
// --------------------------------------

`timescale 1ns/100ps

`include "hub_settings.svh"

module hubMemory (
	input  logic                   sysclk,
	// link side
	input  logic [`HUB_ADDR_W-1:0] aAddr,
	input  logic                   aWen,
	input  logic [`HUB_DATA_W-1:0] aWdata,
	output logic [`HUB_DATA_W-1:0] aRdata,
	// ethernet side
	input  logic [`HUB_ADDR_W-1:0] bAddr,
	input  logic                   bWen,
	input  logic [`HUB_DATA_W-1:0] bWdata,
	output logic [`HUB_DATA_W-1:0] bRdata
);

	logic [`HUB_DATA_W-1:0] mem [0:`HUB_MEM_DEPTH-1];

	// --------------------------------------
	// both ports, read before write
	// --------------------------------------
	always_ff @(posedge sysclk) begin
		if (aWen)
			mem[aAddr] <= aWdata;
		if (bWen)
			mem[bAddr] <= bWdata;
		aRdata <= mem[aAddr];  // one cycle latency
		bRdata <= mem[bAddr];  // old word on a cross-port write
	end

	// link and ethernet sides work on separate RAM regions
	noWriteClash: assert property (@(posedge sysclk)
		!(aWen && bWen && aAddr == bAddr))
		else $error("both ports write address %h", aAddr);

endmodule

// File: source/hubControl.sv
// --------------------------------------
// hub controller top level
// status sequencer, register bus arbiter
// and hub RAM
// --------------------------------------

`timescale 1ns/100ps

`include "hub_settings.svh"

module hubControl (
	input  logic                   sysclk,
	input  logic                   RSTN,
	// completion strobes from the links
	input  hubPkg::hubEvents_t     events,
	input  logic [`ACK_CODE_W-1:0] ackCode,
	input  logic [`NODE_W-1:0]     numNode,
	input  logic                   modeBroadcast,
	output hubPkg::hubStatus_u     status,
	output logic                   bcModeLed,
	// ethernet engines
	input  hubPkg::regReq_t        initReq,
	input  hubPkg::regReq_t        transReq,
	input  hubPkg::regReq_t        recvReq,
	output hubPkg::regReq_t        regBus,
	// firewire link RAM port
	input  logic [`HUB_ADDR_W-1:0] linkAddr,
	input  logic                   linkWen,
	input  logic [`HUB_DATA_W-1:0] linkWdata,
	output logic [`HUB_DATA_W-1:0] linkRdata,
	output logic [`HUB_DATA_W-1:0] ethRdata
);

	// --------------------------------------
	// procedural control
	// --------------------------------------
	hubSequencer hubSequencer_i (
		.sysclk        (sysclk),
		.RSTN          (RSTN),
		.events        (events),
		.ackCode       (ackCode),
		.numNode       (numNode),
		.modeBroadcast (modeBroadcast),
		.status        (status),
		.bcModeLed     (bcModeLed)
	);

	// owner picked from status
	regBusArbiter regBusArbiter_i (
		.status   (status),
		.initReq  (initReq),
		.transReq (transReq),
		.recvReq  (recvReq),
		.regBus   (regBus)
	);

	// --------------------------------------
	// hub RAM
	// --------------------------------------
	hubMemory hubMemory_i (
		.sysclk (sysclk),
		.aAddr  (linkAddr),
		.aWen   (linkWen),
		.aWdata (linkWdata),
		.aRdata (linkRdata),
		.bAddr  (regBus.memAddr),   // ethernet side follows bus owner
		.bWen   (regBus.memWen),
		.bWdata (regBus.memWdata),
		.bRdata (ethRdata)
	);

endmodule

// File: bench/hubControlTb.sv
// --------------------------------------
// hub controller testbench
// clock, reset, directed and random stimulus
// reference status model, per-cycle compare
// cycle limit
// --------------------------------------

`timescale 1ns/100ps

`include "hub_settings.svh"

module hubControlTb;

	// event bit positions inside hubEvents_t, msb first
	localparam int evInitDone  = 8;
	localparam int evNodeSet   = 7;
	localparam int evPcReqNew  = 6;
	localparam int evPcReqTxed = 5;
	localparam int evBcReqTxed = 4;
	localparam int evAck       = 3;
	localparam int evResp      = 2;
	localparam int evBcResp    = 1;
	localparam int evTransDone = 0;
	// two 4096-cycle timeouts, the rest needs well under 2000 cycles
	localparam int cycleLimit  = 20000;

	logic                   sysclk;
	logic                   RSTN;
	hubPkg::hubEvents_t     events;
	logic [`ACK_CODE_W-1:0] ackCode;
	logic [`NODE_W-1:0]     numNode;
	logic                   modeBroadcast;
	hubPkg::hubStatus_u     status;
	logic                   bcModeLed;
	hubPkg::regReq_t        initReq;
	hubPkg::regReq_t        transReq;
	hubPkg::regReq_t        recvReq;
	hubPkg::regReq_t        regBus;
	logic [`HUB_ADDR_W-1:0] linkAddr;
	logic                   linkWen;
	logic [`HUB_DATA_W-1:0] linkWdata;
	logic [`HUB_DATA_W-1:0] linkRdata;
	logic [`HUB_DATA_W-1:0] ethRdata;

	logic [5:0]         refStatus;   // reference model state
	logic [5:0]         nxt;
	int                 refWait;
	logic [`NODE_W-1:0] refPkt;
	logic [`NODE_W-1:0] refNum;
	logic               refMode;
	logic               reqRandom;   // shuffle requester inputs each cycle
	int                 cycleCount;
	int                 errorCount;

	hubControl hubControl_i (.*);

	always #10 sysclk = ~sysclk;

	// --------------------------------------
	// helpers
	// --------------------------------------
	task automatic check(input string name, input logic [71:0] got, input logic [71:0] exp);
		if (got !== exp) begin
			errorCount++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			$display("Some tests failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// expected status after one clock edge
	function automatic logic [5:0] nextStatus(input logic [5:0] prev, input hubPkg::hubEvents_t ev,
		input logic [3:0] ack, input logic bcIn, input logic lastNode, input logic expired);
		logic [5:0] n;
		logic [5:0] idleSt;
		logic [5:0] respSt;
		n      = prev;
		idleSt = prev[5] ? hubPkg::StPcIdle : hubPkg::StSetupIdle;  // bit 5 marks pc mode
		respSt = prev[5] ? hubPkg::StPcResp : hubPkg::StSetupResp;
		case (prev)
			hubPkg::StInit:
				if (ev.ethInitDone) n = hubPkg::StSetupIdle;
			hubPkg::StSetupIdle:
				if (ev.nodeSet) n = bcIn ? hubPkg::StBcReq : hubPkg::StPcIdle;
				else if (ev.pcReqNew) n = hubPkg::StSetupTx;
			hubPkg::StPcIdle:
				if (ev.pcReqNew) n = hubPkg::StPcTx;
			hubPkg::StSetupTx, hubPkg::StPcTx:
				if (ev.pcReqTxed) n = prev[5] ? hubPkg::StPcAck : hubPkg::StSetupAck;
			hubPkg::StSetupAck, hubPkg::StPcAck:
				if (ev.ackRxed) n = (ack == `ACK_PEND) ? respSt : idleSt;
				else if (expired) n = idleSt;
			hubPkg::StSetupResp, hubPkg::StPcResp:
				if (ev.respRxed) n = prev[5] ? hubPkg::StPcReply : hubPkg::StSetupReply;
				else if (expired) n = idleSt;
			hubPkg::StSetupReply, hubPkg::StPcReply:
				if (ev.transDone) n = idleSt;
			hubPkg::StBcReq:
				if (ev.bcReqTxed) n = hubPkg::StBcAck;
			hubPkg::StBcAck:
				if (ev.ackRxed) n = (ack == `ACK_DONE) ? hubPkg::StBcCollect : hubPkg::StBcReq;
			hubPkg::StBcCollect:
				if (ev.bcRespRxed && lastNode) n = hubPkg::StBcReply;
			hubPkg::StBcReply:
				if (ev.transDone) n = hubPkg::StBcReq;
			default:
				n = hubPkg::StInit;
		endcase
		return n;
	endfunction

	// owner rule, idle bus parks in word mode
	function automatic hubPkg::regReq_t expectedBus(input logic [5:0] st,
		input hubPkg::regReq_t i, input hubPkg::regReq_t t, input hubPkg::regReq_t r);
		hubPkg::regReq_t idle;
		idle        = '0;
		idle.isWord = 1'b1;
		if (st == hubPkg::StInit)
			return i;
		else if (st[3])
			return t;
		else if (st[4])
			return r;
		return idle;
	endfunction

	function automatic hubPkg::regReq_t randomReq(input logic wenOk);
		logic [95:0]     raw;
		hubPkg::regReq_t r;
		raw      = {$urandom, $urandom, $urandom};
		r        = raw[$bits(hubPkg::regReq_t)-1:0];
		r.memWen = r.memWen & wenOk;  // only receive may write the RAM
		return r;
	endfunction

	function automatic logic [31:0] fillWord(input logic [10:0] a);
		return {~a, 10'h35a, a};
	endfunction

	// one-cycle strobe, called on a falling edge
	task automatic pulse(input int which, input logic [3:0] ack);
		hubPkg::hubEvents_t ev;
		ev        = '0;
		ev[which] = 1'b1;
		events    = ev;
		ackCode   = ack;
		@(negedge sysclk);
		events    = '0;
	endtask

	task automatic pcTransaction(input logic [3:0] ack);
		pulse(evPcReqNew, 4'h0);
		pulse(evPcReqTxed, 4'h0);
		pulse(evAck, ack);
		if (ack == `ACK_PEND) begin
			pulse(evResp, 4'h0);
			pulse(evTransDone, 4'h0);
		end
	endtask

	// cycles spent in a wait state without any strobe
	task automatic measureWait(input logic [5:0] st);
		int n;
		n = 0;
		while (status.code == st) begin
			n++;
			@(negedge sysclk);
		end
		check("timeout cycles", n, `HUB_TIMEOUT_MAX + 1);
	endtask

	// --------------------------------------
	// reference model and compare
	// --------------------------------------
	always @(posedge sysclk or negedge RSTN) begin
		if (!RSTN) begin
			refStatus = hubPkg::StInit;
			refWait   = 0;
			refPkt    = '0;
			refNum    = '0;
			refMode   = 1'b0;
		end else begin
			nxt = nextStatus(refStatus, events, ackCode, modeBroadcast,
				refPkt == refNum, refWait == `HUB_TIMEOUT_MAX);
			if (nxt == refStatus && refStatus inside {hubPkg::StSetupAck,
				hubPkg::StSetupResp, hubPkg::StPcAck, hubPkg::StPcResp})
				refWait++;
			else
				refWait = 0;  // fresh count on each entry
			if (nxt != hubPkg::StBcCollect)
				refPkt = '0;
			else if (refStatus == hubPkg::StBcCollect && events.bcRespRxed)
				refPkt++;
			if (refStatus == hubPkg::StSetupIdle && events.nodeSet) begin
				refMode = modeBroadcast;
				refNum  = numNode;
			end
			refStatus = nxt;
		end
	end

	// mid low phase, away from both edges
	always begin
		@(negedge sysclk);
		#5;
		check("status", status, refStatus);
		check("bcModeLed", bcModeLed, refMode);
		check("regBus", regBus, expectedBus(refStatus, initReq, transReq, recvReq));
	end

	always @(negedge sysclk) begin
		if (reqRandom) begin
			initReq  = randomReq(1'b0);
			transReq = randomReq(1'b0);
			recvReq  = randomReq(1'b1);
		end
	end

	always @(posedge sysclk) begin
		cycleCount++;
		if (cycleCount >= cycleLimit) begin
			$display("run timed out after %0d cycles", cycleCount);
			$display("Some tests failed");
			$fatal(1, "cycle limit reached");
		end
	end

	// --------------------------------------
	// stimulus
	// --------------------------------------
	initial begin
		logic [`NODE_W-1:0]     nodes;
		logic [`ACK_CODE_W-1:0] bad;
		sysclk = 1'b0;
		RSTN = 1'b0;
		events = '0;
		ackCode = '0;
		numNode = '0;
		modeBroadcast = 1'b0;
		initReq = '0;
		transReq = '0;
		recvReq = '0;
		linkAddr = '0;
		linkWen = 1'b0;
		linkWdata = '0;
		reqRandom = 1'b0;
		cycleCount = 0;
		errorCount = 0;
		void'($urandom(32'h0e5c_3aac));
		repeat (2) @(negedge sysclk);
		RSTN = 1'b1;
		check("status", status, hubPkg::StInit);
		check("bcModeLed", bcModeLed, 1'b0);
		reqRandom = 1'b1;
		// setup flow, done then pending
		pulse(evInitDone, 4'h0);
		pcTransaction(`ACK_DONE);
		pcTransaction(`ACK_PEND);
		// node-set and new request together, node-set wins
		events = '0;
		events.nodeSet = 1'b1;
		events.pcReqNew = 1'b1;
		@(negedge sysclk);
		events = '0;
		check("status", status, hubPkg::StPcIdle);
		// pc mode with random ack codes, error codes included
		repeat (16)
			pcTransaction(4'($urandom));
		// timeouts in ack and response waits
		pulse(evPcReqNew, 4'h0);
		pulse(evPcReqTxed, 4'h0);
		measureWait(hubPkg::StPcAck);
		pulse(evPcReqNew, 4'h0);
		pulse(evPcReqTxed, 4'h0);
		pulse(evAck, `ACK_PEND);
		measureWait(hubPkg::StPcResp);
		check("status", status, hubPkg::StPcIdle);
		// memory, receive writes port B in idle, link reads back on port A
		reqRandom = 1'b0;
		@(negedge sysclk);
		initReq = '0;
		transReq = '0;
		recvReq = '0;
		for (int k = 0; k < 8; k++) begin
			recvReq.memAddr = 11'h200 + 11'(k);
			recvReq.memWen = 1'b1;
			recvReq.memWdata = fillWord(11'h200 + 11'(k));
			@(negedge sysclk);
		end
		recvReq.memWen = 1'b0;
		for (int k = 0; k < 8; k++) begin
			linkAddr = 11'h200 + 11'(k);
			@(negedge sysclk);
			check("linkRdata", linkRdata, fillWord(11'h200 + 11'(k)));
		end
		// link writes, read back on ethRdata while transmit owns port B
		for (int k = 0; k < 8; k++) begin
			linkAddr = 11'h4a0 + 11'(k);
			linkWen = 1'b1;
			linkWdata = fillWord(11'h4a0 + 11'(k));
			@(negedge sysclk);
		end
		linkWen = 1'b0;
		pulse(evPcReqNew, 4'h0);
		pulse(evPcReqTxed, 4'h0);
		pulse(evAck, `ACK_PEND);
		pulse(evResp, 4'h0);
		check("status", status, hubPkg::StPcReply);
		for (int k = 0; k < 8; k++) begin
			transReq.memAddr = 11'h4a0 + 11'(k);
			@(negedge sysclk);
			check("ethRdata", ethRdata, fillWord(11'h4a0 + 11'(k)));
		end
		pulse(evTransDone, 4'h0);
		reqRandom = 1'b1;
		// broadcast mode needs a fresh setup
		RSTN = 1'b0;
		repeat (2) @(negedge sysclk);
		RSTN = 1'b1;
		pulse(evInitDone, 4'h0);
		nodes = 4'($urandom_range(15, 0));
		numNode = nodes;
		modeBroadcast = 1'b1;
		pulse(evNodeSet, 4'h0);
		numNode = '0;
		modeBroadcast = 1'b0;  // latched already
		check("status", status, hubPkg::StBcReq);
		check("bcModeLed", bcModeLed, 1'b1);
		repeat (3) begin
			pulse(evBcReqTxed, 4'h0);
			bad = 4'($urandom);
			if (bad == `ACK_DONE)
				bad = `ACK_PEND;
			pulse(evAck, bad);
			check("status", status, hubPkg::StBcReq);
			pulse(evBcReqTxed, 4'h0);
			pulse(evAck, `ACK_DONE);
			for (int n = 0; n <= nodes; n++) begin
				check("status", status, hubPkg::StBcCollect);
				pulse(evBcResp, 4'h0);
			end
			check("status", status, hubPkg::StBcReply);
			pulse(evTransDone, 4'h0);
		end
		repeat (4) @(negedge sysclk);
		if (errorCount == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: compile.f
+incdir+source
source/hubPkg.sv
source/hubSequencer.sv
source/regBusArbiter.sv
source/hubMemory.sv
source/hubControl.sv
bench/hubControlTb.sv

// File: Bender.yml
package:
  name: hub_control

export_include_dirs:
  - source

sources:
  - files:
      - source/hubPkg.sv
      - source/hubSequencer.sv
      - source/regBusArbiter.sv
      - source/hubMemory.sv
      - source/hubControl.sv
  - target: test
    files:
      - bench/hubControlTb.sv
